// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_top -f files.f -Mdir obj_dir
	./obj_dir/Vtb_top | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: files.f
verilog/soc_pkg.sv
verilog/ahb_decoder_mux.sv
verilog/ahb_gpio.sv
verilog/ahb_seg7x8.sv
verilog/led_chaser.sv
verilog/soc_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: tb/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
  parameter int GPIO_W    = 20,
  parameter int SHIFT_DIV = 4,
  parameter int LED_DIV   = 16
) (
  input  logic               CLK_CM3,
  input  logic               rst,
  input  soc_pkg::ahb_mreq_t mreq,
  input  soc_pkg::ahb_rsp_t  mrsp,
  input  logic [GPIO_W-1:0]  gpio_in,
  input  logic [GPIO_W-1:0]  gpio_out,
  input  logic [GPIO_W-1:0]  gpio_oe,
  input  logic               sh_cp,
  input  logic               st_cp,
  input  logic               ds,
  input  logic [3:0]         led,
  output int                 errors,
  output int                 frames_done,
  output int                 frames_left
);
  import soc_pkg::*;

  localparam int FRAME_LEN = 64 * 2 * SHIFT_DIV + SHIFT_DIV;

  // Standard active-high gfedcba codes, 0 to F
  logic [6:0] seg_table [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                                 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

  // Transfer in its data phase
  logic              dp_valid;
  logic              dp_active;
  logic              dp_write;
  logic [1:0]        dp_slot;
  logic [1:0]        dp_idx;
  int                dp_waits;
  // Register model
  logic [GPIO_W-1:0] m_out;
  logic [GPIO_W-1:0] m_oe;
  logic [GPIO_W-1:0] in_s1;
  logic [GPIO_W-1:0] in_s2;
  logic [31:0]       m_digits;
  logic [7:0]        m_dp;
  // Frame engine model
  int                eng_left;
  logic              eng_pend;
  logic              commit_frame;
  logic              start_now;
  logic [63:0]       exp_q[$];
  logic [63:0]       exp_frame;
  logic [63:0]       shift_bits;
  int                bit_cnt;
  logic              sh_prev;
  logic              st_prev;
  logic [3:0]        led_prev;
  int                led_cycles;
  logic              after_rst;
  logic [31:0]       exp_rd;

  initial
  begin
    errors      = 0;
    frames_done = 0;
    frames_left = 0;
  end

  function automatic logic [63:0] build_frame(input logic [31:0] digits, input logic [7:0] dp);
    logic [63:0] f;
    f = '0;
    // Digit 7 ends up in the top byte, first on the wire
    for (int i = 7; i >= 0; i--)
      f = {f[55:0], dp[i], seg_table[digits[4*i +: 4]]};
    return f;
  endfunction

  task check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got)
    begin
      $display("Error: %s expected %h got %h at %0t", name, exp, got, $time);
      errors++;
    end
  endtask

  task report(input string what);
    $display("%s at %0t", what, $time);
    errors++;
  endtask

  task finish_transfer;
    if (!dp_active)
    begin
      if (mrsp.resp || dp_waits != 0)
        report("IDLE transfer did not get a zero-wait OKAY response");
    end
    else if (dp_slot != SLOT_GPIO && dp_slot != SLOT_SEG7)
    begin
      check_val("mrsp.resp", 32'd1, {31'd0, mrsp.resp});
      check_val("error wait cycles", 32'd1, dp_waits);
      check_val("mrsp.rdata", 32'd0, mrsp.rdata);
    end
    else
    begin
      if (mrsp.resp || dp_waits != 0)
        report("Mapped slot gave an error or a wait state");
      if (dp_slot == SLOT_GPIO && dp_write)
      begin
        if (dp_idx == REG_DATA)
          m_out = mreq.wdata[GPIO_W-1:0];
        if (dp_idx == REG_AUX)
          m_oe = mreq.wdata[GPIO_W-1:0];
      end
      else if (dp_slot == SLOT_GPIO)
      begin
        case (dp_idx)
          REG_DATA: exp_rd = 32'(m_out);
          REG_AUX:  exp_rd = 32'(m_oe);
          REG_STAT: exp_rd = 32'(in_s2);
          default:  exp_rd = 32'd0;
        endcase
        check_val("gpio rdata", exp_rd, mrsp.rdata);
      end
      else if (dp_write)
      begin
        if (dp_idx == REG_DATA)
        begin
          m_digits     = mreq.wdata;
          commit_frame = 1'b1;
        end
        if (dp_idx == REG_AUX)
        begin
          m_dp         = mreq.wdata[7:0];
          commit_frame = 1'b1;
        end
      end
      else
      begin
        case (dp_idx)
          REG_DATA: exp_rd = m_digits;
          REG_AUX:  exp_rd = {24'd0, m_dp};
          REG_STAT: exp_rd = {31'd0, eng_left > 0};
          default:  exp_rd = 32'd0;
        endcase
        check_val("seg7 rdata", exp_rd, mrsp.rdata);
      end
    end
  endtask

  task frame_end;
    frames_done++;
    if (bit_cnt != 64)
      report($sformatf("Frame was latched after %0d bits instead of 64", bit_cnt));
    if (exp_q.size() == 0)
      report("Latch pulse came with no frame expected");
    else
    begin
      exp_frame = exp_q.pop_front();
      check_val("seg7 frame[63:32]", exp_frame[63:32], shift_bits[63:32]);
      check_val("seg7 frame[31:0]", exp_frame[31:0], shift_bits[31:0]);
    end
    bit_cnt = 0;
  endtask

  always @(posedge CLK_CM3)
  begin
    if (rst)
    begin
      dp_valid   = 1'b0;
      m_out      = '0;
      m_oe       = '0;
      m_digits   = 32'd0;
      m_dp       = 8'd0;
      eng_left   = 0;
      eng_pend   = 1'b0;
      exp_q.delete();
      bit_cnt    = 0;
      sh_prev    = 1'b0;
      st_prev    = 1'b0;
      led_prev   = 4'b0001;
      led_cycles = 0;
      after_rst  = 1'b1;
    end
    else
    begin
      check_val("gpio_out", 32'(m_out), 32'(gpio_out));
      check_val("gpio_oe", 32'(m_oe), 32'(gpio_oe));

      if (after_rst)
        check_val("led", 32'h1, {28'd0, led});
      after_rst = 1'b0;
      if (!$onehot(led))
        report($sformatf("LED pattern %h is not one-hot", led));
      else if (led != led_prev && led != {led_prev[2:0], led_prev[3]})
        report($sformatf("LED moved from %h to %h, not a one-step rotation", led_prev, led));
      // One step every LED_DIV clocks
      if (led != led_prev)
      begin
        check_val("led period", 32'(LED_DIV), 32'(led_cycles));
        led_cycles = 0;
      end
      else if (led_cycles == LED_DIV)
        report($sformatf("LED stayed at %h for more than %0d cycles", led, LED_DIV));
      led_cycles++;
      led_prev = led;

      commit_frame = 1'b0;
      if (dp_valid)
      begin
        if (!mrsp.readyout)
          dp_waits++;
        else
        begin
          finish_transfer();
          dp_valid = 1'b0;
        end
      end
      if (mrsp.readyout)
      begin
        dp_valid  = 1'b1;
        dp_active = (mreq.trans == TRANS_NONSEQ) || (mreq.trans == TRANS_SEQ);
        dp_write  = mreq.write;
        dp_slot   = mreq.address[13:12];
        dp_idx    = mreq.address[3:2];
        dp_waits  = 0;
      end

      // A frame snapshots the registers as they are when it starts
      start_now = (commit_frame || eng_pend) && eng_left == 0;
      if (eng_left > 0)
        eng_left--;
      if (start_now)
      begin
        eng_left = FRAME_LEN;
        eng_pend = 1'b0;
        exp_q.push_back(build_frame(m_digits, m_dp));
      end
      else if (commit_frame)
        eng_pend = 1'b1;

      if (sh_cp && !sh_prev)
      begin
        shift_bits = {shift_bits[62:0], ds};
        bit_cnt++;
      end
      if (st_cp && !st_prev)
        frame_end();
      sh_prev = sh_cp;
      st_prev = st_cp;
    end
    frames_left = exp_q.size();
    // Two-flop input synchronizer runs through reset
    in_s2 = in_s1;
    in_s1 = gpio_in;
  end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import soc_pkg::*;

  localparam int GPIO_W    = 20;
  localparam int SHIFT_DIV = 4;
  localparam int LED_DIV   = 16;
  localparam logic [1:0] TRANS_IDLE = 2'b00;

  // Watchdog sized from the number of transfers and a full frame each
  localparam int N_XFERS   = 300;
  localparam int FRAME_CYC = 64 * 2 * SHIFT_DIV + SHIFT_DIV;
  localparam int MARGIN    = 20;
  localparam longint WATCHDOG_NS = longint'(N_XFERS) * (FRAME_CYC + MARGIN) * 10;

  logic              CLK_CM3;
  logic              rst;
  ahb_mreq_t         mreq;
  ahb_rsp_t          mrsp;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic              sh_cp;
  logic              st_cp;
  logic              ds;
  logic [3:0]        led;
  int                errors;
  int                frames_done;
  int                frames_left;
  int                tb_errs;
  int                err_mark;
  int                tests_run;
  int                tests_bad;
  int                frame_mark;
  logic [31:0]       rd;

  initial
    CLK_CM3 = 1'b0;

  always #5 CLK_CM3 = ~CLK_CM3;

  soc_top #(.GPIO_W(GPIO_W), .SHIFT_DIV(SHIFT_DIV), .LED_DIV(LED_DIV)) UUT (
    .CLK_CM3    (CLK_CM3),
    .rst        (rst),
    .mreq       (mreq),
    .mrsp       (mrsp),
    .gpio_in    (gpio_in),
    .gpio_out   (gpio_out),
    .gpio_oe    (gpio_oe),
    .seg7_sh_cp (sh_cp),
    .seg7_st_cp (st_cp),
    .seg7_ds    (ds),
    .led        (led)
  );

  tb_checker #(.GPIO_W(GPIO_W), .SHIFT_DIV(SHIFT_DIV), .LED_DIV(LED_DIV)) u_checker (
    .CLK_CM3     (CLK_CM3),
    .rst         (rst),
    .mreq        (mreq),
    .mrsp        (mrsp),
    .gpio_in     (gpio_in),
    .gpio_out    (gpio_out),
    .gpio_oe     (gpio_oe),
    .sh_cp       (sh_cp),
    .st_cp       (st_cp),
    .ds          (ds),
    .led         (led),
    .errors      (errors),
    .frames_done (frames_done),
    .frames_left (frames_left)
  );

  // One non-pipelined word transfer, inputs change on the falling edge
  task automatic bus_xfer(input logic [1:0] slot, input logic [1:0] idx, input logic wr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge CLK_CM3);
    mreq.address = {18'd0, slot, 8'd0, idx, 2'b00};
    mreq.trans   = TRANS_NONSEQ;
    mreq.size    = SIZE_WORD;
    mreq.write   = wr;
    while (!mrsp.readyout)
      @(negedge CLK_CM3);
    @(negedge CLK_CM3);
    mreq.trans = TRANS_IDLE;
    mreq.wdata = wdata;
    while (!mrsp.readyout)
      @(negedge CLK_CM3);
    rdata = mrsp.rdata;
  endtask

  // Busy can drop for one cycle between merged frames
  task automatic wait_seg_idle;
    int quiet;
    logic [31:0] st;
    quiet = 0;
    while (quiet < 2)
    begin
      bus_xfer(SLOT_SEG7, REG_STAT, 1'b0, 32'd0, st);
      if (st[0])
        quiet = 0;
      else
        quiet++;
    end
  endtask

  task automatic end_test(input string name);
    int e;
    e = errors + tb_errs - err_mark;
    tests_run++;
    if (e != 0)
      tests_bad++;
    $display("test %-14s %s, %0d errors", name, (e == 0) ? "ok" : "failing", e);
    err_mark = errors + tb_errs;
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(32'hbf64));
    rst       = 1'b1;
    mreq      = '0;
    gpio_in   = '0;
    tb_errs   = 0;
    err_mark  = 0;
    tests_run = 0;
    tests_bad = 0;
    repeat (4) @(posedge CLK_CM3);
    @(negedge CLK_CM3);
    rst = 1'b0;

    repeat (40)
    begin
      bus_xfer(SLOT_GPIO, 2'($urandom % 2), 1'b1, $urandom, rd);
      bus_xfer(SLOT_GPIO, 2'($urandom % 4), 1'b0, 32'd0, rd);
    end
    end_test("gpio_regs");

    repeat (10)
    begin
      @(negedge CLK_CM3);
      gpio_in = GPIO_W'($urandom);
      repeat (3) @(negedge CLK_CM3);
      bus_xfer(SLOT_GPIO, REG_STAT, 1'b0, 32'd0, rd);
    end
    end_test("gpio_inputs");

    repeat (4)
    begin
      wait_seg_idle();
      bus_xfer(SLOT_SEG7, REG_DATA, 1'b1, $urandom, rd);
      bus_xfer(SLOT_SEG7, REG_AUX, 1'b1, $urandom, rd);
      wait_seg_idle();
      bus_xfer(SLOT_SEG7, REG_DATA, 1'b0, 32'd0, rd);
      bus_xfer(SLOT_SEG7, REG_AUX, 1'b0, 32'd0, rd);
    end
    end_test("seg_frames");

    wait_seg_idle();
    frame_mark = frames_done;
    bus_xfer(SLOT_SEG7, REG_DATA, 1'b1, $urandom, rd);
    repeat (3)
      bus_xfer(SLOT_SEG7, REG_DATA, 1'b1, $urandom, rd);
    bus_xfer(SLOT_SEG7, REG_AUX, 1'b1, $urandom, rd);
    wait_seg_idle();
    if (frames_done - frame_mark != 2)
    begin
      $display("Error: frames_done delta expected %h got %h", 2, frames_done - frame_mark);
      tb_errs++;
    end
    end_test("write_merge");

    repeat (20)
      bus_xfer(2'd2 + 2'($urandom % 2), 2'($urandom % 4), 1'($urandom), $urandom, rd);
    @(negedge CLK_CM3);
    mreq.address = {18'd0, 2'd3, 12'd0};
    repeat (3) @(negedge CLK_CM3);
    end_test("unmapped");

    repeat (LED_DIV * 10) @(negedge CLK_CM3);
    repeat (40)
      bus_xfer(2'($urandom % 4), 2'($urandom % 4), 1'($urandom), $urandom, rd);
    wait_seg_idle();
    if (frames_left != 0)
    begin
      $display("Frames were expected but never latched (%0d left)", frames_left);
      tb_errs++;
    end
    end_test("led_and_mix");

    $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_bad, errors + tb_errs);
    if (errors + tb_errs == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verilog/ahb_decoder_mux.sv
`timescale 1ns/1ps

module ahb_decoder_mux (
  input  logic                CLK_CM3,
  input  logic                rst,
  input  soc_pkg::ahb_mreq_t  mreq,
  output soc_pkg::ahb_rsp_t   mrsp,
  output soc_pkg::ahb_sreq_t  gpio_req,
  input  soc_pkg::ahb_rsp_t   gpio_rsp,
  output soc_pkg::ahb_sreq_t  seg_req,
  input  soc_pkg::ahb_rsp_t   seg_rsp
);
  import soc_pkg::*;

  ahb_addr_u  addr_u;
  ahb_sreq_t  fan;
  logic       active;
  logic       dp_active;
  logic [1:0] dp_slot;
  logic       dp_mapped;
  logic       err_second;

  assign addr_u = mreq.address;
  assign active = (mreq.trans == TRANS_NONSEQ) || (mreq.trans == TRANS_SEQ);

  // Common request, sel filled in per slave
  always_comb
  begin
    fan.sel     = 1'b0;
    fan.address = mreq.address;
    fan.trans   = mreq.trans;
    fan.size    = mreq.size;
    fan.write   = mreq.write;
    fan.wdata   = mreq.wdata;
    fan.ready   = mrsp.readyout;
    gpio_req     = fan;
    gpio_req.sel = (addr_u.dec.slot == SLOT_GPIO);
    seg_req      = fan;
    seg_req.sel  = (addr_u.dec.slot == SLOT_SEG7);
  end

  // Slot of the transfer now in its data phase
  always_ff @(posedge CLK_CM3)
  begin
    if (rst)
    begin
      dp_active <= 1'b0;
      dp_slot   <= 2'd0;
    end
    else if (mrsp.readyout)
    begin
      dp_active <= active;
      dp_slot   <= addr_u.dec.slot;
    end
  end

  assign dp_mapped = (dp_slot == SLOT_GPIO) || (dp_slot == SLOT_SEG7);

  // Second cycle of the error response
  always_ff @(posedge CLK_CM3)
  begin
    if (rst)
      err_second <= 1'b0;
    else
      err_second <= dp_active && !dp_mapped && !err_second;
  end

  always_comb
  begin
    mrsp.readyout = 1'b1;
    mrsp.rdata    = 32'd0;
    mrsp.resp     = 1'b0;
    if (dp_active)
    begin
      case (dp_slot)
        SLOT_GPIO: mrsp = gpio_rsp;
        SLOT_SEG7: mrsp = seg_rsp;
        default:
        begin
          // Unmapped slot, wait state then ready
          mrsp.readyout = err_second;
          mrsp.resp     = 1'b1;
        end
      endcase
    end
  end

  a_err_two_cycle: assert property (@(posedge CLK_CM3) disable iff (rst)
    (mrsp.resp && !mrsp.readyout) |=> (mrsp.resp && mrsp.readyout));

  a_word_only: assert property (@(posedge CLK_CM3) disable iff (rst)
    (active && mrsp.readyout) |-> (mreq.size == SIZE_WORD));

endmodule

// File: verilog/ahb_gpio.sv
`timescale 1ns/1ps

module ahb_gpio #(
  parameter int GPIO_W = 20
) (
  input  logic               CLK_CM3,
  input  logic               rst,
  input  soc_pkg::ahb_sreq_t req,
  output soc_pkg::ahb_rsp_t  rsp,
  input  logic [GPIO_W-1:0]  gpio_in,
  output logic [GPIO_W-1:0]  gpio_out,
  output logic [GPIO_W-1:0]  gpio_oe
);
  import soc_pkg::*;

  ahb_addr_u         addr_u;
  logic              active;
  logic              wr_pend;
  logic [1:0]        reg_idx;
  logic [GPIO_W-1:0] in_meta;
  logic [GPIO_W-1:0] in_sync;

  assign addr_u = req.address;
  assign active = (req.trans == TRANS_NONSEQ) || (req.trans == TRANS_SEQ);

  // Address phase capture
  always_ff @(posedge CLK_CM3)
  begin
    if (rst)
      wr_pend <= 1'b0;
    else if (req.ready)
      wr_pend <= req.sel && active && req.write;
  end

  always_ff @(posedge CLK_CM3)
  begin
    if (req.ready)
      reg_idx <= addr_u.dec.offset[3:2];
  end

  // Data phase commit
  always_ff @(posedge CLK_CM3)
  begin
    if (rst)
    begin
      gpio_out <= '0;
      gpio_oe  <= '0;
    end
    else if (wr_pend && req.ready)
    begin
      if (reg_idx == REG_DATA)
        gpio_out <= req.wdata[GPIO_W-1:0];
      if (reg_idx == REG_AUX)
        gpio_oe <= req.wdata[GPIO_W-1:0];
    end
  end

  // Pin synchronizer
  always_ff @(posedge CLK_CM3)
  begin
    in_meta <= gpio_in;
    in_sync <= in_meta;
  end

  always_comb
  begin
    rsp.readyout = 1'b1;
    rsp.resp     = 1'b0;
    rsp.rdata    = 32'd0;
    case (reg_idx)
      REG_DATA: rsp.rdata[GPIO_W-1:0] = gpio_out;
      REG_AUX:  rsp.rdata[GPIO_W-1:0] = gpio_oe;
      REG_STAT: rsp.rdata[GPIO_W-1:0] = in_sync;
      default:  rsp.rdata = 32'd0;
    endcase
  end

  a_no_wait: assert property (@(posedge CLK_CM3) disable iff (rst)
    rsp.readyout);

endmodule

// File: verilog/ahb_seg7x8.sv
`timescale 1ns/1ps

module ahb_seg7x8 #(
  parameter int SHIFT_DIV = 4
) (
  input  logic               CLK_CM3,
  input  logic               rst,
  input  soc_pkg::ahb_sreq_t req,
  output soc_pkg::ahb_rsp_t  rsp,
  output logic               sh_cp,
  output logic               st_cp,
  output logic               ds
);
  import soc_pkg::*;

  localparam int DIV_W = $clog2(2 * SHIFT_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST   = DIV_W'(2 * SHIFT_DIV - 1);
  localparam logic [DIV_W-1:0] LATCH_LAST = DIV_W'(SHIFT_DIV - 1);
  localparam logic [DIV_W-1:0] HIGH_FROM  = DIV_W'(SHIFT_DIV);

  ahb_addr_u        addr_u;
  logic             active;
  logic             wr_pend;
  logic [1:0]       reg_idx;
  logic             wr_commit;
  logic             frame_req;
  logic [31:0]      digits;
  logic [7:0]       dp_mask;
  logic [31:0]      digits_nxt;
  logic [7:0]       dp_nxt;
  logic [63:0]      frame_nxt;
  logic [63:0]      frame_q;
  logic             pending;
  logic             shifting;
  logic             latching;
  logic             busy;
  logic             start;
  logic [DIV_W-1:0] div_cnt;
  logic [5:0]       bit_cnt;

  assign addr_u = req.address;
  assign active = (req.trans == TRANS_NONSEQ) || (req.trans == TRANS_SEQ);

  always_ff @(posedge CLK_CM3)
  begin
    if (rst)
      wr_pend <= 1'b0;
    else if (req.ready)
      wr_pend <= req.sel && active && req.write;
  end

  always_ff @(posedge CLK_CM3)
  begin
    if (req.ready)
      reg_idx <= addr_u.dec.offset[3:2];
  end

  assign wr_commit = wr_pend && req.ready;
  assign frame_req = wr_commit && (reg_idx == REG_DATA || reg_idx == REG_AUX);

  // Register values after this cycle's write, so a frame starting now sees it
  always_comb
  begin
    digits_nxt = digits;
    dp_nxt     = dp_mask;
    if (wr_commit && reg_idx == REG_DATA)
      digits_nxt = req.wdata;
    if (wr_commit && reg_idx == REG_AUX)
      dp_nxt = req.wdata[7:0];
  end

  always_ff @(posedge CLK_CM3)
  begin
    if (rst)
    begin
      digits  <= 32'd0;
      dp_mask <= 8'd0;
    end
    else
    begin
      digits  <= digits_nxt;
      dp_mask <= dp_nxt;
    end
  end

  // Digit 7 lands in the top byte and goes out first
  always_comb
  begin
    for (int i = 0; i < 8; i++)
      frame_nxt[8*i +: 8] = {dp_nxt[i], hex_to_seg(digits_nxt[4*i +: 4])};
  end

  assign busy  = shifting || latching;
  assign start = (frame_req || pending) && !busy;

  always_ff @(posedge CLK_CM3)
  begin
    if (rst)
    begin
      pending  <= 1'b0;
      shifting <= 1'b0;
      latching <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= 6'd0;
    end
    else if (start)
    begin
      pending  <= 1'b0;
      shifting <= 1'b1;
      div_cnt  <= '0;
      bit_cnt  <= 6'd0;
    end
    else
    begin
      // Requests during a frame merge into one
      if (frame_req)
        pending <= 1'b1;
      if (shifting)
      begin
        if (div_cnt == DIV_LAST)
        begin
          div_cnt <= '0;
          if (bit_cnt == 6'd63)
          begin
            shifting <= 1'b0;
            latching <= 1'b1;
          end
          else
            bit_cnt <= bit_cnt + 6'd1;
        end
        else
          div_cnt <= div_cnt + 1'b1;
      end
      else if (latching)
      begin
        if (div_cnt == LATCH_LAST)
        begin
          latching <= 1'b0;
          div_cnt  <= '0;
        end
        else
          div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK_CM3)
  begin
    if (start)
      frame_q <= frame_nxt;
    else if (shifting && div_cnt == DIV_LAST)
      frame_q <= {frame_q[62:0], 1'b0};
  end

  // ds moves with the falling edge of sh_cp
  assign sh_cp = shifting && (div_cnt >= HIGH_FROM);
  assign st_cp = latching;
  assign ds    = shifting && frame_q[63];

  always_comb
  begin
    rsp.readyout = 1'b1;
    rsp.resp     = 1'b0;
    case (reg_idx)
      REG_DATA: rsp.rdata = digits;
      REG_AUX:  rsp.rdata = {24'd0, dp_mask};
      REG_STAT: rsp.rdata = {31'd0, busy};
      default:  rsp.rdata = 32'd0;
    endcase
  end

  a_clk_excl: assert property (@(posedge CLK_CM3) disable iff (rst)
    !(sh_cp && st_cp));

endmodule

// File: verilog/led_chaser.sv
`timescale 1ns/1ps

module led_chaser #(
  parameter int LED_DIV = 16
) (
  input  logic       CLK_CM3,
  input  logic       rst,
  output logic [3:0] led
);

  localparam int CNT_W = (LED_DIV > 1) ? $clog2(LED_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LED_DIV - 1);

  logic [CNT_W-1:0] pre_cnt;
  logic             tick;

  assign tick = (pre_cnt == CNT_LAST);

  always_ff @(posedge CLK_CM3)
  begin
    if (rst)
    begin
      pre_cnt <= '0;
      led     <= 4'b0001;
    end
    else if (tick)
    begin
      pre_cnt <= '0;
      // Rotate toward the higher bit
      led     <= {led[2:0], led[3]};
    end
    else
      pre_cnt <= pre_cnt + 1'b1;
  end

  a_onehot: assert property (@(posedge CLK_CM3) disable iff (rst) $onehot(led));

endmodule

// File: verilog/soc_pkg.sv
package soc_pkg;

  // Master request at the subsystem boundary
  typedef struct packed {
    logic [31:0] address;
    logic [1:0]  trans;
    logic [2:0]  size;
    logic        write;
    logic [31:0] wdata;
  } ahb_mreq_t;

  // Request as seen by one slave
  typedef struct packed {
    logic        sel;
    logic [31:0] address;
    logic [1:0]  trans;
    logic [2:0]  size;
    logic        write;
    logic [31:0] wdata;
    logic        ready;
  } ahb_sreq_t;

  typedef struct packed {
    logic        readyout;
    logic [31:0] rdata;
    logic        resp;
  } ahb_rsp_t;

  typedef struct packed {
    logic [17:0] upper;
    logic [1:0]  slot;
    logic [11:0] offset;
  } ahb_addr_dec_t;

  // Same address word, raw or split into slot and offset
  typedef union packed {
    logic [31:0]   raw;
    ahb_addr_dec_t dec;
  } ahb_addr_u;

  localparam logic [1:0] SLOT_GPIO = 2'd0;
  localparam logic [1:0] SLOT_SEG7 = 2'd1;

  // Register index, address bits 3..2
  localparam logic [1:0] REG_DATA = 2'd0;
  localparam logic [1:0] REG_AUX  = 2'd1;
  localparam logic [1:0] REG_STAT = 2'd2;

  localparam logic [1:0] TRANS_NONSEQ = 2'b10;
  localparam logic [1:0] TRANS_SEQ    = 2'b11;
  localparam logic [2:0] SIZE_WORD    = 3'b010;

  // Active-high gfedcba
  function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
    logic [6:0] seg;
    case (nib)
      4'h0: seg = 7'h3f;
      4'h1: seg = 7'h06;
      4'h2: seg = 7'h5b;
      4'h3: seg = 7'h4f;
      4'h4: seg = 7'h66;
      4'h5: seg = 7'h6d;
      4'h6: seg = 7'h7d;
      4'h7: seg = 7'h07;
      4'h8: seg = 7'h7f;
      4'h9: seg = 7'h6f;
      4'ha: seg = 7'h77;
      4'hb: seg = 7'h7c;
      4'hc: seg = 7'h39;
      4'hd: seg = 7'h5e;
      4'he: seg = 7'h79;
      default: seg = 7'h71;
    endcase
    return seg;
  endfunction

endpackage

// File: verilog/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
  parameter int GPIO_W    = 20,
  parameter int SHIFT_DIV = 4,
  parameter int LED_DIV   = 16
) (
  input  logic               CLK_CM3,
  input  logic               rst,
  input  soc_pkg::ahb_mreq_t mreq,
  output soc_pkg::ahb_rsp_t  mrsp,
  input  logic [GPIO_W-1:0]  gpio_in,
  output logic [GPIO_W-1:0]  gpio_out,
  output logic [GPIO_W-1:0]  gpio_oe,
  output logic               seg7_sh_cp,
  output logic               seg7_st_cp,
  output logic               seg7_ds,
  output logic [3:0]         led
);
  import soc_pkg::*;

  ahb_sreq_t gpio_req;
  ahb_rsp_t  gpio_rsp;
  ahb_sreq_t seg_req;
  ahb_rsp_t  seg_rsp;

  ahb_decoder_mux u_decoder (
    .CLK_CM3  (CLK_CM3),
    .rst      (rst),
    .mreq     (mreq),
    .mrsp     (mrsp),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp),
    .seg_req  (seg_req),
    .seg_rsp  (seg_rsp)
  );

  // Pads are split outside, data and enable per pin
  ahb_gpio #(.GPIO_W(GPIO_W)) u_gpio (
    .CLK_CM3  (CLK_CM3),
    .rst      (rst),
    .req      (gpio_req),
    .rsp      (gpio_rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

  ahb_seg7x8 #(.SHIFT_DIV(SHIFT_DIV)) u_seg7 (
    .CLK_CM3 (CLK_CM3),
    .rst     (rst),
    .req     (seg_req),
    .rsp     (seg_rsp),
    .sh_cp   (seg7_sh_cp),
    .st_cp   (seg7_st_cp),
    .ds      (seg7_ds)
  );

  led_chaser #(.LED_DIV(LED_DIV)) u_chaser (
    .CLK_CM3 (CLK_CM3),
    .rst     (rst),
    .led     (led)
  );

endmodule
